// ==== hdl/cmd_issue.sv ====
// command output registers
`timescale 1ns/1ps

module cmd_issue import cpu_ctrl_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  logic             fetch_go,
    input  logic             exec_go,
    input  logic             fill_go,
    input  logic [WE_W-1:0]  fb_we,
    input  logic [REG_W-1:0] fb_dst,
    input  alu_op_t          fb_alu_op,
    input  logic [OP_W-1:0]  fb_imm,
    input  logic             fb_smux,
    input  logic             fb_flag_we,
    input  logic             fb_inc_rfp,
    input  logic             fb_dec_rfp,
    input  logic [WE_W-1:0]  sb_we,
    input  logic [REG_W-1:0] sb_dst,
    input  logic [REG_W-1:0] sb_src,
    input  alu_op_t          sb_alu_op,
    input  logic [OP_W-1:0]  sb_imm,
    input  logic             sb_smux,
    input  logic [OP_W-1:0]  fl_imm,
    input  logic [WE_W-1:0]  fl_we,
    input  logic             fl_pc_we,
    output logic [WE_W-1:0]  regs_we,
    output logic [REG_W-1:0] regs_dst,
    output logic [REG_W-1:0] regs_src,
    output alu_op_t          alu_op,
    output logic [OP_W-1:0]  alu_imm,
    output logic             alu_smux,
    output logic             flag_we,
    output logic             inc_rfp,
    output logic             dec_rfp,
    output logic             pc_we
);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            regs_we  <= '0;
            regs_dst <= '0;
            regs_src <= '0;
            alu_op   <= ALU_NOP;
            alu_imm  <= '0;
            alu_smux <= 1'b0;
            flag_we  <= 1'b0;
            inc_rfp  <= 1'b0;
            dec_rfp  <= 1'b0;
            pc_we    <= 1'b0;
        end else begin
            regs_we <= fetch_go ? fb_we : exec_go ? sb_we : fill_go ? fl_we : '0;
            flag_we <= fetch_go && fb_flag_we; // pulses last one cycle
            inc_rfp <= fetch_go && fb_inc_rfp;
            dec_rfp <= fetch_go && fb_dec_rfp;
            pc_we   <= fill_go && fl_pc_we;
            if (fetch_go) begin
                regs_dst <= fb_dst;
                alu_op   <= fb_alu_op;
                alu_imm  <= fb_imm;
                alu_smux <= fb_smux;
            end else if (exec_go) begin
                regs_dst <= sb_dst;
                regs_src <= sb_src;        // only the second byte names a source
                alu_op   <= sb_alu_op;
                alu_imm  <= sb_imm;
                alu_smux <= sb_smux;
            end else if (fill_go) begin
                alu_imm  <= fl_imm;        // upper bytes joined to the low byte
            end
        end
    end

endmodule

// ==== hdl/cpu_ctrl.sv ====
// instruction sequencing controller top
`timescale 1ns/1ps

module cpu_ctrl import cpu_ctrl_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic [OP_W-1:0]    op,
    input  logic               op_ok,
    output logic [FETCH_W-1:0] fetched,
    output logic [WE_W-1:0]    regs_we,
    output logic [REG_W-1:0]   regs_dst,
    output logic [REG_W-1:0]   regs_src,
    output alu_op_t            alu_op,
    output logic [OP_W-1:0]    alu_imm,
    output logic               alu_smux,
    output logic               flag_we,
    output logic               inc_rfp,
    output logic               dec_rfp,
    output logic               pc_we
);

    logic fetch_go, exec_go, fill_go;
    logic fb_go_fill;

    logic [FETCH_W-1:0] fb_fetched, sb_fetched, fl_fetched;
    phase_t             fb_next, sb_next;
    logic [WE_W-1:0]    fb_we, sb_we, fl_we, fill_we, sb_fill_we;
    logic [REG_W-1:0]   fb_dst, sb_dst, sb_src, pre_reg;
    alu_op_t            fb_alu_op, sb_alu_op;
    logic [OP_W-1:0]    fb_imm, sb_imm, fl_imm;
    logic               fb_smux, sb_smux;
    logic               fb_flag_we, fb_inc_rfp, fb_dec_rfp;
    logic               fill_req, fill_pc, sb_fill_req, fl_pc_we;
    fill_t              fill_kind, sb_fill_kind;
    logic [1:0]         pre_zz;

    assign fb_go_fill = fetch_go && fill_req;

    first_byte_dec u_first (
        .clk, .rst, .op, .fetch_go,
        .fb_fetched, .fb_next, .fb_we, .fb_dst, .fb_alu_op, .fb_imm, .fb_smux,
        .fb_flag_we, .fb_inc_rfp, .fb_dec_rfp,
        .fill_req, .fill_kind, .fill_we, .fill_pc, .pre_zz, .pre_reg
    );

    second_byte_dec u_second (
        .op, .pre_zz, .pre_reg,
        .sb_fetched, .sb_next, .sb_we, .sb_dst, .sb_src, .sb_alu_op, .sb_imm,
        .sb_smux, .sb_fill_req, .sb_fill_kind, .sb_fill_we
    );

    imm_fill u_fill (
        .clk, .rst, .op, .fb_go_fill, .exec_go,
        .fill_req, .fill_kind, .fill_we, .fill_pc,
        .sb_fill_req, .sb_fill_kind, .sb_fill_we,
        .imm_lo(alu_imm[7:0]),
        .fl_fetched, .fl_imm, .fl_we, .fl_pc_we
    );

    phase_seq u_phase (
        .clk, .rst, .op_ok, .fb_fetched, .sb_fetched, .fl_fetched,
        .fb_next, .sb_next, .fetched, .fetch_go, .exec_go, .fill_go
    );

    cmd_issue u_issue (
        .clk, .rst, .fetch_go, .exec_go, .fill_go,
        .fb_we, .fb_dst, .fb_alu_op, .fb_imm, .fb_smux,
        .fb_flag_we, .fb_inc_rfp, .fb_dec_rfp,
        .sb_we, .sb_dst, .sb_src, .sb_alu_op, .sb_imm, .sb_smux,
        .fl_imm, .fl_we, .fl_pc_we,
        .regs_we, .regs_dst, .regs_src, .alu_op, .alu_imm, .alu_smux,
        .flag_we, .inc_rfp, .dec_rfp, .pc_we
    );

endmodule

// ==== hdl/cpu_ctrl_pkg.sv ====
// cpu controller shared definitions
package cpu_ctrl_pkg;

    localparam int OP_W    = 32;               // opcode window, byte 0 in the low byte
    localparam int REG_W   = 8;                // register code
    localparam int WE_W    = 3;                // one-hot byte, word, long
    localparam int FETCH_W = 2;                // consumed byte count

    localparam logic [3:0] REG_BANK_CUR = 4'hE; // current bank
    localparam logic [3:0] REG_BANK_ALT = 4'hF; // alternate registers

    typedef enum logic [1:0] {
        PH_FETCH,
        PH_EXEC,
        PH_FILL
    } phase_t;

    typedef enum logic [5:0] {
        ALU_NOP,
        ALU_MOVE,
        ALU_ADD,
        ALU_ADC,
        ALU_SUB,
        ALU_SBC,
        ALU_AND,
        ALU_OR,
        ALU_CPL,
        ALU_CCF
    } alu_op_t;

    // immediate bytes still to come
    typedef enum logic [1:0] {
        FILL_WORD,                             // one byte
        FILL_LONG,                             // three bytes
        FILL_ADDR24                            // two bytes
    } fill_t;

    function automatic logic [WE_W-1:0] expand_zz(input logic [1:0] zz);
        return (zz == 2'd0) ? 3'b001 : (zz == 2'd1) ? 3'b010 : 3'b100;
    endfunction

    function automatic logic [REG_W-1:0] expand_reg(input logic [2:0] r, input logic [1:0] zz);
        if (zz == 2'd0)
            return {REG_BANK_CUR, r[2:1], 1'b0, ~r[0]};
        return {(r[2] ? REG_BANK_ALT : REG_BANK_CUR), r[1:0], 2'b00};
    endfunction

endpackage

// ==== hdl/first_byte_dec.sv ====
// first opcode byte decoder
`timescale 1ns/1ps

module first_byte_dec import cpu_ctrl_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic [OP_W-1:0]    op,
    input  logic               fetch_go,
    output logic [FETCH_W-1:0] fb_fetched,
    output phase_t             fb_next,
    output logic [WE_W-1:0]    fb_we,
    output logic [REG_W-1:0]   fb_dst,
    output alu_op_t            fb_alu_op,
    output logic [OP_W-1:0]    fb_imm,
    output logic               fb_smux,
    output logic               fb_flag_we,
    output logic               fb_inc_rfp,
    output logic               fb_dec_rfp,
    output logic               fill_req,
    output fill_t              fill_kind,
    output logic [WE_W-1:0]    fill_we,
    output logic               fill_pc,
    output logic [1:0]         pre_zz,
    output logic [REG_W-1:0]   pre_reg
);

    logic [1:0]       ld_zz;     // size of LD R,# from bits 6..4
    logic             is_prefix;
    logic [REG_W-1:0] nx_reg;

    assign ld_zz = (op[6:4] == 3'd2) ? 2'd0 : (op[6:4] == 3'd3) ? 2'd1 : 2'd2;

    always_comb begin
        fb_fetched = 2'd1;                     // unsupported bytes still consume one
        fb_next    = PH_FETCH;
        fb_we      = '0;
        fb_dst     = '0;
        fb_alu_op  = ALU_NOP;
        fb_imm     = '0;
        fb_smux    = 1'b0;
        fb_flag_we = 1'b0;
        fb_inc_rfp = 1'b0;
        fb_dec_rfp = 1'b0;
        fill_req   = 1'b0;
        fill_kind  = FILL_WORD;
        fill_we    = '0;
        fill_pc    = 1'b0;
        is_prefix  = 1'b0;
        nx_reg     = expand_reg(op[2:0], op[5:4]);
        casez (op[7:0])
            8'h00: fb_fetched = 2'd1;          // nop
            8'h12: begin                       // ccf
                fb_alu_op  = ALU_CCF;
                fb_flag_we = 1'b1;
            end
            8'h0c: fb_inc_rfp = 1'b1;          // incf
            8'h0d: fb_dec_rfp = 1'b1;          // decf
            8'b0010_0???, 8'b0011_0???, 8'b0100_0???: begin // LD R,#
                fb_fetched = 2'd2;
                fb_dst     = expand_reg(op[2:0], ld_zz);
                fb_alu_op  = ALU_MOVE;
                fb_imm     = {24'd0, op[15:8]};
                fb_smux    = 1'b1;
                if (ld_zz == 2'd0) begin
                    fb_we = expand_zz(ld_zz);
                end else begin
                    fill_req  = 1'b1;          // rest of the immediate follows
                    fill_kind = (ld_zz == 2'd1) ? FILL_WORD : FILL_LONG;
                    fill_we   = expand_zz(ld_zz);
                    fb_next   = PH_FILL;
                end
            end
            8'b0001_101?: begin                // jp #16 / #24
                fb_fetched = 2'd2;
                fb_imm     = {24'd0, op[15:8]};
                fill_req   = 1'b1;
                fill_kind  = op[0] ? FILL_ADDR24 : FILL_WORD;
                fill_pc    = 1'b1;
                fb_next    = PH_FILL;
            end
            8'b11??_1???: begin                // prefix with short register
                if (op[5:4] != 2'b11) begin
                    is_prefix = 1'b1;
                    fb_dst    = nx_reg;
                    fb_next   = PH_EXEC;
                end
            end
            8'b11??_0111: begin                // prefix with extended register code
                if (op[5:4] != 2'b11) begin
                    is_prefix  = 1'b1;
                    nx_reg     = op[15:8];
                    fb_dst     = nx_reg;
                    fb_fetched = 2'd2;
                    fb_next    = PH_EXEC;
                end
            end
            default: fb_fetched = 2'd1;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pre_zz  <= 2'd0;
            pre_reg <= '0;
        end else if (fetch_go && is_prefix) begin
            pre_zz  <= op[5:4];
            pre_reg <= nx_reg;                 // operand for the second byte
        end
    end

endmodule

// ==== hdl/imm_fill.sv ====
// immediate fill stage
`timescale 1ns/1ps

module imm_fill import cpu_ctrl_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic [OP_W-1:0]    op,
    input  logic               fb_go_fill,
    input  logic               exec_go,
    input  logic               fill_req,
    input  fill_t              fill_kind,
    input  logic [WE_W-1:0]    fill_we,
    input  logic               fill_pc,
    input  logic               sb_fill_req,
    input  fill_t              sb_fill_kind,
    input  logic [WE_W-1:0]    sb_fill_we,
    input  logic [7:0]         imm_lo,
    output logic [FETCH_W-1:0] fl_fetched,
    output logic [OP_W-1:0]    fl_imm,
    output logic [WE_W-1:0]    fl_we,
    output logic               fl_pc_we
);

    fill_t           kind_q;
    logic [WE_W-1:0] we_q;                     // pending register write
    logic            pc_q;                     // pending jump

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            kind_q <= FILL_WORD;
            we_q   <= '0;
            pc_q   <= 1'b0;
        end else if (fb_go_fill && fill_req) begin
            kind_q <= fill_kind;
            we_q   <= fill_we;
            pc_q   <= fill_pc;
        end else if (exec_go && sb_fill_req) begin
            kind_q <= sb_fill_kind;
            we_q   <= sb_fill_we;
            pc_q   <= 1'b0;
        end
    end

    // low byte already sits in alu_imm
    always_comb begin
        case (kind_q)
            FILL_LONG: begin
                fl_fetched = 2'd3;
                fl_imm     = {op[23:0], imm_lo};
            end
            FILL_ADDR24: begin
                fl_fetched = 2'd2;
                fl_imm     = {8'd0, op[15:0], imm_lo};
            end
            default: begin
                fl_fetched = 2'd1;
                fl_imm     = {16'd0, op[7:0], imm_lo};
            end
        endcase
    end

    assign fl_we    = we_q;
    assign fl_pc_we = pc_q;

endmodule

// ==== hdl/phase_seq.sv ====
// phase sequencer
`timescale 1ns/1ps

module phase_seq import cpu_ctrl_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic               op_ok,
    input  logic [FETCH_W-1:0] fb_fetched,
    input  logic [FETCH_W-1:0] sb_fetched,
    input  logic [FETCH_W-1:0] fl_fetched,
    input  phase_t             fb_next,
    input  phase_t             sb_next,
    output logic [FETCH_W-1:0] fetched,
    output logic               fetch_go,
    output logic               exec_go,
    output logic               fill_go
);

    phase_t             phase;
    phase_t             nx_phase;
    logic               refill_wait;           // window is stale for one cycle
    logic               step;
    logic [FETCH_W-1:0] sel_fetched;

    assign step = op_ok && !refill_wait;

    always_comb begin
        case (phase)
            PH_EXEC: begin
                sel_fetched = sb_fetched;
                nx_phase    = sb_next;
            end
            PH_FILL: begin
                sel_fetched = fl_fetched;
                nx_phase    = PH_FETCH;
            end
            default: begin
                sel_fetched = fb_fetched;
                nx_phase    = fb_next;
            end
        endcase
    end

    assign fetched  = step ? sel_fetched : '0;
    assign fetch_go = step && (phase != PH_EXEC) && (phase != PH_FILL);
    assign exec_go  = step && (phase == PH_EXEC);
    assign fill_go  = step && (phase == PH_FILL);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            phase       <= PH_FETCH;
            refill_wait <= 1'b0;
        end else begin
            refill_wait <= (fetched != '0);
            if (step)
                phase <= nx_phase;
        end
    end

endmodule

// ==== hdl/second_byte_dec.sv ====
// second byte decoder for prefixed instructions
`timescale 1ns/1ps

module second_byte_dec import cpu_ctrl_pkg::*; (
    input  logic [OP_W-1:0]    op,
    input  logic [1:0]         pre_zz,
    input  logic [REG_W-1:0]   pre_reg,
    output logic [FETCH_W-1:0] sb_fetched,
    output phase_t             sb_next,
    output logic [WE_W-1:0]    sb_we,
    output logic [REG_W-1:0]   sb_dst,
    output logic [REG_W-1:0]   sb_src,
    output alu_op_t            sb_alu_op,
    output logic [OP_W-1:0]    sb_imm,
    output logic               sb_smux,
    output logic               sb_fill_req,
    output fill_t              sb_fill_kind,
    output logic [WE_W-1:0]    sb_fill_we
);

    logic [WE_W-1:0]  size_we;
    logic [REG_W-1:0] big_r;                   // R from byte 0

    assign size_we = expand_zz(pre_zz);
    assign big_r   = expand_reg(op[2:0], pre_zz);

    always_comb begin
        sb_fetched   = 2'd1;
        sb_next      = PH_FETCH;
        sb_we        = '0;
        sb_dst       = pre_reg;
        sb_src       = pre_reg;
        sb_alu_op    = ALU_NOP;
        sb_imm       = '0;
        sb_smux      = 1'b0;
        sb_fill_req  = 1'b0;
        sb_fill_kind = FILL_WORD;
        sb_fill_we   = '0;
        casez (op[7:0])
            8'b1000_1???: begin                // LD R,r
                sb_dst    = big_r;
                sb_alu_op = ALU_MOVE;
                sb_we     = size_we;
            end
            8'b1001_1???: begin                // LD r,R
                sb_src    = big_r;
                sb_alu_op = ALU_MOVE;
                sb_we     = size_we;
            end
            8'b1000_0???, 8'b1001_0???, 8'b1010_0???,
            8'b1100_0???, 8'b1110_0???: begin  // R,r arithmetic
                sb_dst    = big_r;
                sb_we     = size_we;
                case (op[7:4])
                    4'h8:    sb_alu_op = ALU_ADD;
                    4'h9:    sb_alu_op = ALU_ADC;
                    4'ha:    sb_alu_op = ALU_SUB;
                    4'hc:    sb_alu_op = ALU_AND;
                    default: sb_alu_op = ALU_OR;
                endcase
            end
            8'h06: begin                       // cpl r
                sb_alu_op = ALU_CPL;
                sb_we     = size_we;
            end
            8'hc8, 8'hc9, 8'hca, 8'hcb, 8'hcc, 8'hce: begin // r,# arithmetic
                sb_fetched = 2'd2;
                sb_smux    = 1'b1;
                sb_imm     = {24'd0, op[15:8]};
                case (op[2:0])
                    3'd0:    sb_alu_op = ALU_ADD;
                    3'd1:    sb_alu_op = ALU_ADC;
                    3'd2:    sb_alu_op = ALU_SUB;
                    3'd3:    sb_alu_op = ALU_SBC;
                    3'd4:    sb_alu_op = ALU_AND;
                    default: sb_alu_op = ALU_OR;
                endcase
                if (pre_zz == 2'd0) begin
                    sb_we = size_we;
                end else begin
                    sb_fill_req  = 1'b1;       // write waits for the upper bytes
                    sb_fill_kind = (pre_zz == 2'd1) ? FILL_WORD : FILL_LONG;
                    sb_fill_we   = size_we;
                    sb_next      = PH_FILL;
                end
            end
            default: sb_fetched = 2'd1;        // skip, back to fetch
        endcase
    end

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# build the cpu_ctrl testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing \
    --timescale 1ns/1ps \
    --top-module tb_cpu_ctrl \
    -f sim.f \
    -o sim_cpu_ctrl

./obj_dir/sim_cpu_ctrl

// ==== sim.f ====
hdl/cpu_ctrl_pkg.sv
hdl/first_byte_dec.sv
hdl/second_byte_dec.sv
hdl/imm_fill.sv
hdl/phase_seq.sv
hdl/cmd_issue.sv
hdl/cpu_ctrl.sv
tests/tb_clk_gen.sv
tests/tb_cpu_ctrl.sv

// ==== tests/tb_clk_gen.sv ====
// testbench clock source
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int PERIOD_NS = 40
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;   // free running
    end

endmodule

// ==== tests/tb_cpu_ctrl.sv ====
// cpu controller testbench
`timescale 1ns/1ps

module tb_cpu_ctrl import cpu_ctrl_pkg::*; ();

    localparam int N_INSTR = 120;
    localparam int MEM_SZ  = 1024;             // worst case program is 7 bytes per instruction

    localparam logic [3:0] P_NONE = 4'b0000;   // flag_we, inc_rfp, dec_rfp, pc_we
    localparam logic [3:0] P_FLAG = 4'b1000;
    localparam logic [3:0] P_INC  = 4'b0100;
    localparam logic [3:0] P_DEC  = 4'b0010;
    localparam logic [3:0] P_PC   = 4'b0001;

    typedef struct packed {
        logic [3:0]       pulse;
        logic [WE_W-1:0]  we;
        logic [REG_W-1:0] dst;
        logic [REG_W-1:0] src;
        alu_op_t          aop;
        logic             smux;
        logic [OP_W-1:0]  imm;
        logic [4:0]       chk;                 // dst, src, aop, smux, imm
    } exp_t;

    logic               clk;
    logic               rst;
    logic [OP_W-1:0]    op;
    logic               op_ok;
    logic [FETCH_W-1:0] fetched;
    logic [WE_W-1:0]    regs_we;
    logic [REG_W-1:0]   regs_dst;
    logic [REG_W-1:0]   regs_src;
    alu_op_t            alu_op;
    logic [OP_W-1:0]    alu_imm;
    logic               alu_smux;
    logic               flag_we;
    logic               inc_rfp;
    logic               dec_rfp;
    logic               pc_we;

    logic [7:0] prog [MEM_SZ];
    int         prog_len;
    int         ptr;                           // start of the opcode window
    int         seed;
    exp_t       exp_q[$];

    tb_clk_gen #(.PERIOD_NS(40)) clk_gen_i (.clk(clk));

    cpu_ctrl dut_i (
        .clk, .rst, .op, .op_ok, .fetched,
        .regs_we, .regs_dst, .regs_src, .alu_op, .alu_imm, .alu_smux,
        .flag_we, .inc_rfp, .dec_rfp, .pc_we
    );

    task automatic abort_run();
        $display("SIMULATION FAILED");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic report_error(input string msg);
        $display("error at %0t: %s", $time, msg);
        abort_run();
    endtask

    task automatic check_reg(input string name, input logic [REG_W-1:0] exp,
                             input logic [REG_W-1:0] act);
        if (act !== exp) begin
            $display("mismatch at %0t: %s expected %h got %h", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_we(input string name, input logic [WE_W-1:0] exp,
                            input logic [WE_W-1:0] act);
        if (act !== exp) begin
            $display("mismatch at %0t: %s expected %b got %b", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_alu(input string name, input alu_op_t exp, input alu_op_t act);
        if (act !== exp) begin
            $display("mismatch at %0t: %s expected %s got %s", $time, name,
                     exp.name(), act.name());
            abort_run();
        end
    endtask

    task automatic check_imm(input string name, input logic [OP_W-1:0] exp,
                             input logic [OP_W-1:0] act);
        if (act !== exp) begin
            $display("mismatch at %0t: %s expected %h got %h", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_pulse(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("mismatch at %0t: %s expected %b got %b", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_fetch(input string name, input logic [FETCH_W-1:0] exp,
                               input logic [FETCH_W-1:0] act);
        if (act !== exp) begin
            $display("mismatch at %0t: %s expected %0d got %0d", $time, name, exp, act);
            abort_run();
        end
    endtask

    function automatic logic [7:0] rnd8();
        int r;
        r = $random(seed);
        return r[7:0];
    endfunction

    function automatic void put_byte(input logic [7:0] b);
        prog[prog_len] = b;
        prog_len = prog_len + 1;
    endfunction

    function automatic void put_rand(input int n);
        for (int i = 0; i < n; i++)
            put_byte(rnd8());
    endfunction

    function automatic int imm_bytes(input logic [1:0] zz);
        return (zz == 2'd0) ? 1 : (zz == 2'd1) ? 2 : 4;
    endfunction

    // register prefix followed by one second byte
    function automatic void gen_prefixed(input int r);
        logic [1:0] zz;
        logic [7:0] s;
        zz = (r[5:4] == 2'd3) ? 2'd1 : r[5:4];
        if (r[6]) begin
            put_byte({2'b11, zz, 4'b0111});
            put_rand(1);                       // extended register code
        end else begin
            put_byte({2'b11, zz, 1'b1, r[9:7]});
        end
        case (r[13:10])
            4'd0, 4'd1: s = {5'b10001, r[16:14]};
            4'd2, 4'd3: s = {5'b10011, r[16:14]};
            4'd4:       s = {5'b10000, r[16:14]};
            4'd5:       s = {5'b10010, r[16:14]};
            4'd6:       s = {5'b10100, r[16:14]};
            4'd7:       s = {5'b11000, r[16:14]};
            4'd8:       s = {5'b11100, r[16:14]};
            4'd9:       s = 8'h06;
            4'd10:      s = 8'hc8;
            4'd11:      s = 8'hc9;
            4'd12:      s = 8'hca;
            4'd13:      s = 8'hcb;
            4'd14:      s = 8'hcc;
            default:    s = 8'hce;
        endcase
        put_byte(s);
        if (s inside {8'hc8, 8'hc9, 8'hca, 8'hcb, 8'hcc, 8'hce})
            put_rand(imm_bytes(zz));
    endfunction

    function automatic void gen_program();
        int r;
        for (int k = 0; k < N_INSTR; k++) begin
            r = $random(seed);
            case (r[3:0])
                4'd0: put_byte(8'h00);
                4'd1: put_byte(8'h12);
                4'd2: put_byte(8'h0c);
                4'd3: put_byte(8'h0d);
                4'd4: begin
                    put_byte({5'b00100, r[6:4]});
                    put_rand(1);
                end
                4'd5: begin
                    put_byte({5'b00110, r[6:4]});
                    put_rand(2);
                end
                4'd6: begin
                    put_byte({5'b01000, r[6:4]});
                    put_rand(4);
                end
                4'd7: begin
                    put_byte(8'h1a);
                    put_rand(2);
                end
                4'd8: begin
                    put_byte(8'h1b);
                    put_rand(3);
                end
                default: gen_prefixed(r);
            endcase
        end
    endfunction

    // byte size keeps the low/high half pick, larger sizes select a quad
    function automatic logic [REG_W-1:0] ref_reg(input logic [2:0] r, input logic [1:0] zz);
        if (zz == 2'd0)
            return {REG_BANK_CUR, r[2:1], 1'b0, !r[0]};
        if (r[2])
            return {REG_BANK_ALT, r[1:0], 2'b00};
        return {REG_BANK_CUR, r[1:0], 2'b00};
    endfunction

    function automatic logic [WE_W-1:0] size_we(input logic [1:0] zz);
        return 3'b001 << zz;
    endfunction

    function automatic logic [OP_W-1:0] read_imm(input int at, input int nbytes);
        logic [OP_W-1:0] v;
        v = '0;
        for (int i = 0; i < nbytes; i++)
            v[8*i +: 8] = prog[at + i];       // little endian
        return v;
    endfunction

    function automatic void push_event(input logic [3:0] pulse, input logic [WE_W-1:0] we,
                                       input logic [REG_W-1:0] dst,
                                       input logic [REG_W-1:0] src,
                                       input alu_op_t aop, input logic smux,
                                       input logic [OP_W-1:0] imm, input logic [4:0] chk);
        exp_t e;
        e.pulse = pulse;
        e.we    = we;
        e.dst   = dst;
        e.src   = src;
        e.aop   = aop;
        e.smux  = smux;
        e.imm   = imm;
        e.chk   = chk;
        exp_q.push_back(e);
    endfunction

    // second byte of a prefixed instruction, p points just past it
    function automatic int decode_second(input logic [7:0] s, input logic [1:0] zz,
                                         input logic [REG_W-1:0] pr, input int p);
        alu_op_t aop;
        int      n;
        n = imm_bytes(zz);
        if (s[7:3] == 5'b10001) begin
            push_event(P_NONE, size_we(zz), ref_reg(s[2:0], zz), pr, ALU_MOVE, 1'b0, '0,
                       5'b11111);
            return p;
        end
        if (s[7:3] == 5'b10011) begin
            push_event(P_NONE, size_we(zz), pr, ref_reg(s[2:0], zz), ALU_MOVE, 1'b0, '0,
                       5'b11111);
            return p;
        end
        if (s == 8'h06) begin
            push_event(P_NONE, size_we(zz), pr, pr, ALU_CPL, 1'b0, '0, 5'b11111);
            return p;
        end
        if (s inside {8'hc8, 8'hc9, 8'hca, 8'hcb, 8'hcc, 8'hce}) begin
            case (s[2:0])
                3'd0:    aop = ALU_ADD;
                3'd1:    aop = ALU_ADC;
                3'd2:    aop = ALU_SUB;
                3'd3:    aop = ALU_SBC;
                3'd4:    aop = ALU_AND;
                default: aop = ALU_OR;
            endcase
            push_event(P_NONE, size_we(zz), pr, pr, aop, 1'b1, read_imm(p, n), 5'b11111);
            return p + n;
        end
        case (s[7:4])                          // R,r arithmetic
            4'h8:    aop = ALU_ADD;
            4'h9:    aop = ALU_ADC;
            4'ha:    aop = ALU_SUB;
            4'hc:    aop = ALU_AND;
            default: aop = ALU_OR;
        endcase
        push_event(P_NONE, size_we(zz), ref_reg(s[2:0], zz), pr, aop, 1'b0, '0, 5'b11111);
        return p;
    endfunction

    function automatic void decode_program();
        int               p;
        int               n;
        logic [7:0]       b;
        logic [1:0]       zz;
        logic [REG_W-1:0] pr;
        p = 0;
        while (p < prog_len) begin
            b = prog[p];
            if (b == 8'h00) begin
                p = p + 1;                     // nop retires silently
            end else if (b == 8'h12) begin
                push_event(P_FLAG, '0, '0, '0, ALU_CCF, 1'b0, '0, 5'b00100);
                p = p + 1;
            end else if (b == 8'h0c || b == 8'h0d) begin
                push_event(b[0] ? P_DEC : P_INC, '0, '0, '0, ALU_NOP, 1'b0, '0, 5'b00000);
                p = p + 1;
            end else if (b[7:3] inside {5'b00100, 5'b00110, 5'b01000}) begin
                zz = (b[7:4] == 4'h2) ? 2'd0 : (b[7:4] == 4'h3) ? 2'd1 : 2'd2;
                n = imm_bytes(zz);
                push_event(P_NONE, size_we(zz), ref_reg(b[2:0], zz), '0, ALU_MOVE, 1'b1,
                           read_imm(p + 1, n), 5'b10111);
                p = p + 1 + n;
            end else if (b == 8'h1a || b == 8'h1b) begin
                n = b[0] ? 3 : 2;
                push_event(P_PC, '0, '0, '0, ALU_NOP, 1'b0, read_imm(p + 1, n), 5'b00001);
                p = p + 1 + n;
            end else begin
                zz = b[5:4];
                if (b[3]) begin
                    pr = ref_reg(b[2:0], zz);
                    p = p + 1;
                end else begin
                    pr = prog[p + 1];          // extended register code
                    p = p + 2;
                end
                p = decode_second(prog[p], zz, pr, p + 1);
            end
        end
    endfunction

    task automatic drive_window();
        logic [7:0] r8;
        r8 = rnd8();
        op = {prog[ptr + 3], prog[ptr + 2], prog[ptr + 1], prog[ptr]};
        op_ok = (ptr < prog_len) && (r8[1:0] != 2'b00);  // mostly high
    endtask

    // every command pulse retires the oldest expected event
    always @(negedge clk) begin : compare
        exp_t e;
        if (!rst && ((regs_we != '0) || flag_we || inc_rfp || dec_rfp || pc_we)) begin
            if (exp_q.size() == 0)
                report_error("command pulse seen after the whole program retired");
            e = exp_q.pop_front();
            check_we("regs_we", e.we, regs_we);
            check_pulse("flag_we", e.pulse[3], flag_we);
            check_pulse("inc_rfp", e.pulse[2], inc_rfp);
            check_pulse("dec_rfp", e.pulse[1], dec_rfp);
            check_pulse("pc_we", e.pulse[0], pc_we);
            if (e.chk[4])
                check_reg("regs_dst", e.dst, regs_dst);
            if (e.chk[3])
                check_reg("regs_src", e.src, regs_src);
            if (e.chk[2])
                check_alu("alu_op", e.aop, alu_op);
            if (e.chk[1])
                check_pulse("alu_smux", e.smux, alu_smux);
            if (e.chk[0])
                check_imm("alu_imm", e.imm, alu_imm);
        end
    end

    initial begin : main
        int step_bytes;
        int prev_bytes;
        int cyc;
        int limit;
        rst = 1'b1;
        op = '0;
        op_ok = 1'b0;
        ptr = 0;
        prog_len = 0;
        seed = 32'h15177d26;
        for (int i = 0; i < MEM_SZ; i++)
            prog[i] = 8'h00;
        gen_program();
        decode_program();

        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        @(negedge clk);                        // idle state before the first step
        check_fetch("fetched", '0, fetched);
        check_we("regs_we", '0, regs_we);
        check_pulse("flag_we", 1'b0, flag_we);
        check_pulse("inc_rfp", 1'b0, inc_rfp);
        check_pulse("dec_rfp", 1'b0, dec_rfp);
        check_pulse("pc_we", 1'b0, pc_we);
        check_alu("alu_op", ALU_NOP, alu_op);
        @(posedge clk);
        #1;
        drive_window();

        prev_bytes = 0;
        cyc = 0;
        limit = 20 * prog_len + 100;
        while (ptr < prog_len) begin
            @(negedge clk);
            step_bytes = int'(fetched);
            if (step_bytes != 0 && prev_bytes != 0)
                report_error("bytes consumed in two consecutive cycles");
            prev_bytes = step_bytes;
            @(posedge clk);
            #1;
            ptr = ptr + step_bytes;
            if (ptr > prog_len)
                report_error("controller consumed more bytes than the program holds");
            drive_window();
            cyc = cyc + 1;
            if (cyc > limit)
                report_error("timeout while stepping through the program");
        end

        cyc = 0;
        while (exp_q.size() != 0) begin
            @(negedge clk);
            cyc = cyc + 1;
            if (cyc > 20)
                report_error("timeout waiting for the last commands to retire");
        end
        repeat (4) @(negedge clk);             // no stray pulses afterwards
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule
